// ==== design/pagerank_cfg.svh ====
`ifndef PAGERANK_CFG_SVH
`define PAGERANK_CFG_SVH

// Graph size and edge slots per node
`define NUM_NODES 8
`define MAX_DEGREE 4

// Q16 ranks
`define FRAC_BITS 16

// Hard stop when the ranks never settle
`define MAX_ITERATIONS 64

`endif

// ==== design/graph_pkg.sv ====
`include "pagerank_cfg.svh"

package graph_pkg;

    // Unsigned fixed point with FRAC_BITS fraction bits
    typedef logic [31:0] rank_t;

    typedef logic [$clog2(`NUM_NODES)-1:0] node_id_t;

    typedef logic [$clog2(`MAX_DEGREE)-1:0] slot_t;

    // Needs one extra bit so a full node can say MAX_DEGREE
    typedef logic [$clog2(`MAX_DEGREE):0] degree_t;

    typedef logic [7:0] iter_t;

    localparam rank_t RANK_ONE = rank_t'(1) << `FRAC_BITS;

endpackage

// ==== design/fsm_pkg.sv ====
package fsm_pkg;

    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_SCATTER,
        CTRL_DAMP,
        CTRL_DELTA,
        CTRL_CHECK,
        CTRL_DONE
    } ctrl_state_t;

    typedef enum logic [2:0] {
        SC_IDLE,
        SC_SCAN,
        SC_EMIT,
        SC_NEXT,
        SC_FINISH
    } scatter_state_t;

endpackage

// ==== design/scatter_if.sv ====
`timescale 1ns/1ps

interface scatter_if;

    // One contribution per valid cycle and no back-pressure
    logic                valid;
    graph_pkg::node_id_t dest;
    graph_pkg::rank_t    value;

    // Zeroes the gather sums before a pass
    logic                clear;

    modport source (
        output valid, dest, value, clear
    );

    modport sink (
        input valid, dest, value, clear
    );

endinterface

// ==== design/edge_scatter.sv ====
`timescale 1ns/1ps
`include "pagerank_cfg.svh"

module edge_scatter (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                scatter_go,
    input  logic                load_ok,
    input  logic                graph_wr,
    input  graph_pkg::node_id_t graph_node,
    input  graph_pkg::slot_t    graph_slot,
    input  graph_pkg::node_id_t graph_dest,
    input  graph_pkg::degree_t  graph_degree,
    input  graph_pkg::rank_t    ranks [`NUM_NODES],
    scatter_if.source           out,
    output logic                scatter_done
);

    fsm_pkg::scatter_state_t state;
    graph_pkg::node_id_t     node;
    graph_pkg::slot_t        slot;
    graph_pkg::rank_t        share;
    graph_pkg::degree_t      degree_mem [`NUM_NODES];
    graph_pkg::node_id_t     dest_mem [`NUM_NODES][`MAX_DEGREE];
    graph_pkg::degree_t      cur_degree;
    logic                    last_node;
    logic                    last_slot;

    assign cur_degree = degree_mem[node];
    assign last_node  = (node == graph_pkg::node_id_t'(`NUM_NODES - 1));
    assign last_slot  = (graph_pkg::degree_t'(slot) + graph_pkg::degree_t'(1) == cur_degree);

    // Out-degree per node
    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `NUM_NODES; i++) begin
                degree_mem[i] <= '0;
            end
        end else if (graph_wr && load_ok) begin
            degree_mem[graph_node] <= graph_degree;
        end
    end

    always_ff @(posedge clock) begin
        if (graph_wr && load_ok) begin
            dest_mem[graph_node][graph_slot] <= graph_dest;
        end
    end

    // Per node share held across all of its edges
    always_ff @(posedge clock) begin
        if (state == fsm_pkg::SC_NEXT && cur_degree != '0) begin
            share <= ranks[node] / graph_pkg::rank_t'(cur_degree);
        end
    end

    // SCAN clears, NEXT visits a node, EMIT sends one edge
    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            state <= fsm_pkg::SC_IDLE;
            node  <= '0;
            slot  <= '0;
        end else begin
            case (state)
                fsm_pkg::SC_IDLE: begin
                    if (scatter_go) begin
                        state <= fsm_pkg::SC_SCAN;
                    end
                end
                fsm_pkg::SC_SCAN: begin
                    node  <= '0;
                    slot  <= '0;
                    state <= fsm_pkg::SC_NEXT;
                end
                fsm_pkg::SC_NEXT: begin
                    slot <= '0;
                    if (cur_degree != '0) begin
                        state <= fsm_pkg::SC_EMIT;
                    end else if (last_node) begin
                        state <= fsm_pkg::SC_FINISH;
                    end else begin
                        // Dangling node sends nothing
                        node <= node + graph_pkg::node_id_t'(1);
                    end
                end
                fsm_pkg::SC_EMIT: begin
                    if (last_slot) begin
                        slot <= '0;
                        if (last_node) begin
                            state <= fsm_pkg::SC_FINISH;
                        end else begin
                            node  <= node + graph_pkg::node_id_t'(1);
                            state <= fsm_pkg::SC_NEXT;
                        end
                    end else begin
                        slot <= slot + graph_pkg::slot_t'(1);
                    end
                end
                fsm_pkg::SC_FINISH: begin
                    state <= fsm_pkg::SC_IDLE;
                end
                default: begin
                    state <= fsm_pkg::SC_IDLE;
                end
            endcase
        end
    end

    assign out.clear    = (state == fsm_pkg::SC_SCAN);
    assign out.valid    = (state == fsm_pkg::SC_EMIT);
    assign out.dest     = dest_mem[node][slot];
    assign out.value    = share;
    assign scatter_done = (state == fsm_pkg::SC_FINISH);

endmodule

// ==== design/rank_accumulator.sv ====
`timescale 1ns/1ps
`include "pagerank_cfg.svh"

module rank_accumulator (
    input  logic             clock,
    input  logic             reset_n,
    scatter_if.sink          in,
    output graph_pkg::rank_t sums [`NUM_NODES]
);

    // clear and valid never arrive together
    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `NUM_NODES; i++) begin
                sums[i] <= '0;
            end
        end else if (in.clear) begin
            for (int i = 0; i < `NUM_NODES; i++) begin
                sums[i] <= '0;
            end
        end else if (in.valid) begin
            // Wraps on overflow like the rest of the datapath
            sums[in.dest] <= sums[in.dest] + in.value;
        end
    end

endmodule

// ==== design/rank_damper.sv ====
`timescale 1ns/1ps
`include "pagerank_cfg.svh"

module rank_damper (
    input  logic             clock,
    input  logic             reset_n,
    input  logic             init,
    input  logic             damp,
    input  logic             delta_go,
    input  graph_pkg::rank_t damping,
    input  graph_pkg::rank_t sums [`NUM_NODES],
    output graph_pkg::rank_t ranks [`NUM_NODES],
    output graph_pkg::rank_t delta
);

    localparam graph_pkg::rank_t INIT_RANK =
        graph_pkg::RANK_ONE / graph_pkg::rank_t'(`NUM_NODES);

    graph_pkg::rank_t prev [`NUM_NODES];
    graph_pkg::rank_t next_rank [`NUM_NODES];
    graph_pkg::rank_t base;
    graph_pkg::rank_t change_sum;

    always_comb begin
        logic [63:0]      product;
        graph_pkg::rank_t diff;

        // Teleport share (1 - d) / N
        base = (graph_pkg::RANK_ONE - damping) / graph_pkg::rank_t'(`NUM_NODES);
        change_sum = '0;
        for (int i = 0; i < `NUM_NODES; i++) begin
            product = {32'b0, damping} * {32'b0, sums[i]};
            next_rank[i] = graph_pkg::rank_t'(product >> `FRAC_BITS) + base;

            // Current ranks against the ones saved before the last damp
            if (ranks[i] >= prev[i]) begin
                diff = ranks[i] - prev[i];
            end else begin
                diff = prev[i] - ranks[i];
            end
            change_sum = change_sum + diff;
        end
    end

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `NUM_NODES; i++) begin
                ranks[i] <= '0;
                prev[i]  <= '0;
            end
            delta <= '0;
        end else if (init) begin
            for (int i = 0; i < `NUM_NODES; i++) begin
                ranks[i] <= INIT_RANK;
                prev[i]  <= INIT_RANK;
            end
            delta <= '0;
        end else if (damp) begin
            for (int i = 0; i < `NUM_NODES; i++) begin
                prev[i]  <= ranks[i];
                ranks[i] <= next_rank[i];
            end
        end else if (delta_go) begin
            delta <= change_sum;
        end
    end

endmodule

// ==== design/pagerank_ctrl.sv ====
`timescale 1ns/1ps
`include "pagerank_cfg.svh"

module pagerank_ctrl (
    input  logic             clock,
    input  logic             reset_n,
    input  logic             start,
    input  logic             scatter_done,
    input  graph_pkg::rank_t delta,
    input  graph_pkg::rank_t threshold,
    output logic             scatter_go,
    output logic             init,
    output logic             damp,
    output logic             delta_go,
    output logic             busy,
    output logic             done,
    output logic             load_ok,
    output graph_pkg::iter_t iterations
);

    fsm_pkg::ctrl_state_t state;
    graph_pkg::iter_t     iter_next;
    logic                 idle_like;
    logic                 accept;
    logic                 finished;

    assign idle_like = (state == fsm_pkg::CTRL_IDLE) || (state == fsm_pkg::CTRL_DONE);
    assign accept    = start && idle_like;
    assign iter_next = iterations + graph_pkg::iter_t'(1);

    // Converged, or out of iterations
    assign finished = (delta < threshold) ||
                      (iter_next == graph_pkg::iter_t'(`MAX_ITERATIONS));

    assign init       = accept;
    assign scatter_go = accept || (state == fsm_pkg::CTRL_CHECK && !finished);
    assign damp       = (state == fsm_pkg::CTRL_DAMP);
    assign delta_go   = (state == fsm_pkg::CTRL_DELTA);
    assign busy       = !idle_like;
    assign done       = (state == fsm_pkg::CTRL_DONE);
    assign load_ok    = idle_like;

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            state      <= fsm_pkg::CTRL_IDLE;
            iterations <= '0;
        end else begin
            case (state)
                fsm_pkg::CTRL_IDLE, fsm_pkg::CTRL_DONE: begin
                    if (accept) begin
                        iterations <= '0;
                        state      <= fsm_pkg::CTRL_SCATTER;
                    end
                end
                fsm_pkg::CTRL_SCATTER: begin
                    if (scatter_done) begin
                        state <= fsm_pkg::CTRL_DAMP;
                    end
                end
                fsm_pkg::CTRL_DAMP: begin
                    state <= fsm_pkg::CTRL_DELTA;
                end
                fsm_pkg::CTRL_DELTA: begin
                    state <= fsm_pkg::CTRL_CHECK;
                end
                fsm_pkg::CTRL_CHECK: begin
                    iterations <= iter_next;
                    state      <= finished ? fsm_pkg::CTRL_DONE : fsm_pkg::CTRL_SCATTER;
                end
                default: begin
                    state <= fsm_pkg::CTRL_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== design/pagerank_top.sv ====
`timescale 1ns/1ps
`include "pagerank_cfg.svh"

module pagerank_top (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                start,
    input  logic                graph_wr,
    input  graph_pkg::node_id_t graph_node,
    input  graph_pkg::slot_t    graph_slot,
    input  graph_pkg::node_id_t graph_dest,
    input  graph_pkg::degree_t  graph_degree,
    input  graph_pkg::rank_t    damping,
    input  graph_pkg::rank_t    threshold,
    input  graph_pkg::node_id_t rank_addr,
    output graph_pkg::rank_t    rank_data,
    output logic                busy,
    output logic                done,
    output graph_pkg::iter_t    iterations
);

    logic             scatter_go;
    logic             scatter_done;
    logic             init;
    logic             damp;
    logic             delta_go;
    logic             load_ok;
    graph_pkg::rank_t delta;
    graph_pkg::rank_t ranks [`NUM_NODES];
    graph_pkg::rank_t sums [`NUM_NODES];

    scatter_if contrib ();

    pagerank_ctrl u_ctrl (
        .clock        (clock),
        .reset_n      (reset_n),
        .start        (start),
        .scatter_done (scatter_done),
        .delta        (delta),
        .threshold    (threshold),
        .scatter_go   (scatter_go),
        .init         (init),
        .damp         (damp),
        .delta_go     (delta_go),
        .busy         (busy),
        .done         (done),
        .load_ok      (load_ok),
        .iterations   (iterations)
    );

    edge_scatter u_scatter (
        .clock        (clock),
        .reset_n      (reset_n),
        .scatter_go   (scatter_go),
        .load_ok      (load_ok),
        .graph_wr     (graph_wr),
        .graph_node   (graph_node),
        .graph_slot   (graph_slot),
        .graph_dest   (graph_dest),
        .graph_degree (graph_degree),
        .ranks        (ranks),
        .out          (contrib.source),
        .scatter_done (scatter_done)
    );

    rank_accumulator u_accum (
        .clock   (clock),
        .reset_n (reset_n),
        .in      (contrib.sink),
        .sums    (sums)
    );

    rank_damper u_damper (
        .clock    (clock),
        .reset_n  (reset_n),
        .init     (init),
        .damp     (damp),
        .delta_go (delta_go),
        .damping  (damping),
        .sums     (sums),
        .ranks    (ranks),
        .delta    (delta)
    );

    // Readable at any time, even mid run
    assign rank_data = ranks[rank_addr];

endmodule

// ==== tests/pagerank_checker.sv ====
`timescale 1ns/1ps
`include "pagerank_cfg.svh"

module pagerank_checker (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                start,
    input  logic                graph_wr,
    input  graph_pkg::node_id_t graph_node,
    input  graph_pkg::slot_t    graph_slot,
    input  graph_pkg::node_id_t graph_dest,
    input  graph_pkg::degree_t  graph_degree,
    input  graph_pkg::rank_t    damping,
    input  graph_pkg::rank_t    threshold,
    input  graph_pkg::node_id_t rank_addr,
    input  graph_pkg::rank_t    rank_data,
    input  logic                busy,
    input  logic                done,
    input  graph_pkg::iter_t    iterations,
    input  logic                reading,
    input  logic                test_end,
    input  logic [1:0]          exit_class,
    output int                  tests_done,
    output int                  tests_failed
);

    localparam logic [1:0]  CLASS_CONVERGE = 2'd0;
    localparam logic [1:0]  CLASS_SINGLE   = 2'd1;
    localparam logic [1:0]  CLASS_CAP      = 2'd2;
    localparam logic [31:0] ONE            = 32'd1 << `FRAC_BITS;

    // Graph as the DUT accepted it
    graph_pkg::degree_t  mirror_deg [`NUM_NODES];
    graph_pkg::node_id_t mirror_dest [`NUM_NODES][`MAX_DEGREE];

    logic [31:0] model_rank [`NUM_NODES];
    logic [7:0]  model_iters;
    int          errors;
    logic        reset_reported;
    logic        run_started;

    initial begin
        tests_done     = 0;
        tests_failed   = 0;
        errors         = 0;
        reset_reported = 1'b0;
        run_started    = 1'b0;
        model_iters    = '0;
        for (int n = 0; n < `NUM_NODES; n++) begin
            mirror_deg[n] = '0;
            model_rank[n] = '0;
        end
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch test %0d: %s expected 0x%08h got 0x%08h",
                     tests_done, name, expected, actual);
            errors++;
        end
    endtask

    task automatic close_test(input string what);
        if (errors == 0) begin
            $display("test %0d %s: ok", tests_done, what);
        end else begin
            $display("test %0d %s: %0d errors", tests_done, what, errors);
            tests_failed++;
        end
        tests_done++;
        errors = 0;
    endtask

    // Fixed point PageRank truncating at every step
    task automatic run_model(input logic [31:0] d, input logic [31:0] thr);
        logic [31:0] cur [`NUM_NODES];
        logic [31:0] sums [`NUM_NODES];
        logic [31:0] share;
        logic [31:0] base;
        logic [31:0] nxt;
        logic [31:0] change;
        logic [63:0] product;
        int          count;
        logic        stop;

        for (int n = 0; n < `NUM_NODES; n++) begin
            cur[n] = ONE / `NUM_NODES;
        end
        base  = (ONE - d) / `NUM_NODES;
        count = 0;
        stop  = 1'b0;
        while (!stop) begin
            for (int n = 0; n < `NUM_NODES; n++) begin
                sums[n] = '0;
            end
            for (int n = 0; n < `NUM_NODES; n++) begin
                // Zero out-degree sends nothing
                if (mirror_deg[n] != '0) begin
                    share = cur[n] / {29'd0, mirror_deg[n]};
                    for (int s = 0; s < int'(mirror_deg[n]); s++) begin
                        sums[mirror_dest[n][s]] = sums[mirror_dest[n][s]] + share;
                    end
                end
            end
            change = '0;
            for (int n = 0; n < `NUM_NODES; n++) begin
                product = {32'd0, d} * {32'd0, sums[n]};
                nxt     = product[`FRAC_BITS +: 32] + base;
                change  = change + ((nxt >= cur[n]) ? nxt - cur[n] : cur[n] - nxt);
                cur[n]  = nxt;
            end
            count++;
            stop = (change < thr) || (count == `MAX_ITERATIONS);
        end
        model_rank  = cur;
        model_iters = 8'(count);
    endtask

    task automatic check_exit_class();
        case (exit_class)
            CLASS_SINGLE: begin
                if (iterations !== 8'd1) begin
                    $display("test %0d: should settle after one iteration but ran %0d",
                             tests_done, iterations);
                    errors++;
                end
            end
            CLASS_CAP: begin
                if (iterations !== 8'(`MAX_ITERATIONS)) begin
                    $display("test %0d: should run to the iteration cap but stopped at %0d",
                             tests_done, iterations);
                    errors++;
                end
            end
            CLASS_CONVERGE: begin
                if (iterations >= 8'(`MAX_ITERATIONS)) begin
                    $display("test %0d: should converge before the iteration cap",
                             tests_done);
                    errors++;
                end
            end
            default: begin
                $display("test %0d: unknown exit class %0d", tests_done, exit_class);
                errors++;
            end
        endcase
    endtask

    // Everything sampled on the falling edge
    always @(negedge clock) begin
        if (!reset_n) begin
            compare("busy", 32'd0, 32'(busy));
            compare("done", 32'd0, 32'(done));
            compare("iterations", 32'd0, 32'(iterations));
        end else begin
            if (!reset_reported) begin
                compare("busy", 32'd0, 32'(busy));
                compare("done", 32'd0, 32'(done));
                compare("iterations", 32'd0, 32'(iterations));
                close_test("after reset");
                reset_reported = 1'b1;
            end
            // One edge after start the run is busy with fresh ranks
            if (run_started) begin
                compare("busy", 32'd1, 32'(busy));
                compare("done", 32'd0, 32'(done));
                compare("iterations", 32'd0, 32'(iterations));
                compare("rank_data", ONE / `NUM_NODES, rank_data);
                run_started = 1'b0;
            end
            if (graph_wr && !busy) begin
                mirror_deg[graph_node]              = graph_degree;
                mirror_dest[graph_node][graph_slot] = graph_dest;
            end
            if (start && !busy) begin
                run_model(damping, threshold);
                run_started = 1'b1;
            end
            if (reading) begin
                compare($sformatf("rank_data[%0d]", rank_addr),
                        model_rank[rank_addr], rank_data);
            end
            if (test_end) begin
                compare("iterations", 32'(model_iters), 32'(iterations));
                compare("done", 32'd1, 32'(done));
                compare("busy", 32'd0, 32'(busy));
                check_exit_class();
                close_test("graph run");
            end
        end
    end

endmodule

// ==== tests/pagerank_tb.sv ====
`timescale 1ns/1ps
`include "pagerank_cfg.svh"

module pagerank_tb;

    localparam int         NUM_TESTS      = 4;
    localparam int         TIMEOUT_CYCLES = 5000;
    localparam logic [1:0] CLASS_CONVERGE = 2'd0;
    localparam logic [1:0] CLASS_SINGLE   = 2'd1;
    localparam logic [1:0] CLASS_CAP      = 2'd2;

    logic                clock;
    logic                reset_n;
    logic                start;
    logic                graph_wr;
    graph_pkg::node_id_t graph_node;
    graph_pkg::slot_t    graph_slot;
    graph_pkg::node_id_t graph_dest;
    graph_pkg::degree_t  graph_degree;
    graph_pkg::rank_t    damping;
    graph_pkg::rank_t    threshold;
    graph_pkg::node_id_t rank_addr;
    graph_pkg::rank_t    rank_data;
    logic                busy;
    logic                done;
    graph_pkg::iter_t    iterations;

    logic                reading;
    logic                test_end;
    logic [1:0]          exit_class;
    int                  tests_done;
    int                  tests_failed;
    int                  timeouts;
    integer              seed;

    // Edge table holds 4 hex digits per node with node 7 first and slot 3 first
    // Degree table holds 1 hex digit per node with node 7 first
    logic [127:0]        tbl_edges [NUM_TESTS];
    logic [31:0]         tbl_degrees [NUM_TESTS];
    graph_pkg::rank_t    tbl_damping [NUM_TESTS];
    graph_pkg::rank_t    tbl_threshold [NUM_TESTS];
    logic [1:0]          tbl_class [NUM_TESTS];
    logic                tbl_random [NUM_TESTS];

    always #2 clock = ~clock;

    pagerank_top uut (
        .clock        (clock),
        .reset_n      (reset_n),
        .start        (start),
        .graph_wr     (graph_wr),
        .graph_node   (graph_node),
        .graph_slot   (graph_slot),
        .graph_dest   (graph_dest),
        .graph_degree (graph_degree),
        .damping      (damping),
        .threshold    (threshold),
        .rank_addr    (rank_addr),
        .rank_data    (rank_data),
        .busy         (busy),
        .done         (done),
        .iterations   (iterations)
    );

    pagerank_checker scoreboard (
        .clock        (clock),
        .reset_n      (reset_n),
        .start        (start),
        .graph_wr     (graph_wr),
        .graph_node   (graph_node),
        .graph_slot   (graph_slot),
        .graph_dest   (graph_dest),
        .graph_degree (graph_degree),
        .damping      (damping),
        .threshold    (threshold),
        .rank_addr    (rank_addr),
        .rank_data    (rank_data),
        .busy         (busy),
        .done         (done),
        .iterations   (iterations),
        .reading      (reading),
        .test_end     (test_end),
        .exit_class   (exit_class),
        .tests_done   (tests_done),
        .tests_failed (tests_failed)
    );

    task automatic fill_table();
        // Ring where every node feeds the next one
        tbl_edges[0]     = 128'h0000_0007_0006_0005_0004_0003_0002_0001;
        tbl_degrees[0]   = 32'h1111_1111;
        tbl_damping[0]   = 32'h0000_D998;
        tbl_threshold[0] = 32'h0000_0001;
        tbl_class[0]     = CLASS_SINGLE;
        tbl_random[0]    = 1'b0;
        // Star into the dangling node 0
        tbl_edges[1]     = 128'h0;
        tbl_degrees[1]   = 32'h1111_1110;
        tbl_damping[1]   = 32'h0000_D999;
        tbl_threshold[1] = 32'h0000_0100;
        tbl_class[1]     = CLASS_CONVERGE;
        tbl_random[1]    = 1'b0;
        // Filled at run time
        tbl_edges[2]     = 128'h0;
        tbl_degrees[2]   = 32'h0;
        tbl_damping[2]   = 32'h0000_D999;
        tbl_threshold[2] = 32'h0000_0000;
        tbl_class[2]     = CLASS_CAP;
        tbl_random[2]    = 1'b1;
        // Loaded over the previous graph while in DONE
        tbl_edges[3]     = 128'h0530_0003_0076_0065_4210_0000_0002_0021;
        tbl_degrees[3]   = 32'h3122_4112;
        tbl_damping[3]   = 32'h0000_C000;
        tbl_threshold[3] = 32'h0000_0100;
        tbl_class[3]     = CLASS_CONVERGE;
        tbl_random[3]    = 1'b0;
    endtask

    task automatic randomize_row(input int row);
        int deg;
        int dest;

        tbl_edges[row]   = '0;
        tbl_degrees[row] = '0;
        for (int n = 0; n < `NUM_NODES; n++) begin
            deg = $unsigned($random(seed)) % (`MAX_DEGREE + 1);
            tbl_degrees[row][n*4 +: 4] = 4'(deg);
            for (int s = 0; s < `MAX_DEGREE; s++) begin
                dest = $unsigned($random(seed)) % `NUM_NODES;
                tbl_edges[row][(n*4 + s)*4 +: 4] = 4'(dest);
            end
        end
    endtask

    task automatic load_graph(input int row);
        for (int n = 0; n < `NUM_NODES; n++) begin
            for (int s = 0; s < `MAX_DEGREE; s++) begin
                @(posedge clock);
                graph_wr     <= 1'b1;
                graph_node   <= graph_pkg::node_id_t'(n);
                graph_slot   <= graph_pkg::slot_t'(s);
                graph_dest   <= tbl_edges[row][(n*4 + s)*4 +: 3];
                graph_degree <= tbl_degrees[row][n*4 +: 3];
            end
        end
        @(posedge clock);
        graph_wr   <= 1'b0;
        damping    <= tbl_damping[row];
        threshold  <= tbl_threshold[row];
        exit_class <= tbl_class[row];
    endtask

    task automatic read_ranks();
        for (int a = 0; a < `NUM_NODES; a++) begin
            @(posedge clock);
            rank_addr <= graph_pkg::node_id_t'(a);
            reading   <= 1'b1;
        end
        @(posedge clock);
        reading  <= 1'b0;
        test_end <= 1'b1;
        @(posedge clock);
        test_end <= 1'b0;
    endtask

    task automatic run_test(input int row);
        int cycles;

        if (tbl_random[row]) begin
            randomize_row(row);
        end
        load_graph(row);
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        // A write while busy must leave the graph alone
        graph_wr     <= 1'b1;
        graph_node   <= '0;
        graph_slot   <= '0;
        graph_dest   <= 3'd7;
        graph_degree <= (tbl_degrees[row][2:0] == 3'd0) ? 3'd1 : 3'd0;
        @(posedge clock);
        graph_wr <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!done && cycles < TIMEOUT_CYCLES);
        if (!done) begin
            $display("test %0d: done did not arrive within %0d cycles", row + 1, cycles);
            timeouts++;
        end else begin
            read_ranks();
        end
    endtask

    initial begin
        seed         = 8222;
        timeouts     = 0;
        clock        = 1'b0;
        reset_n      = 1'b0;
        start        = 1'b0;
        graph_wr     = 1'b0;
        graph_node   = '0;
        graph_slot   = '0;
        graph_dest   = '0;
        graph_degree = '0;
        damping      = '0;
        threshold    = '0;
        rank_addr    = '0;
        reading      = 1'b0;
        test_end     = 1'b0;
        exit_class   = CLASS_CONVERGE;
        fill_table();

        repeat (8) @(posedge clock);
        reset_n <= 1'b1;

        for (int row = 0; row < NUM_TESTS; row++) begin
            // A stuck DUT cannot take a new graph
            if (timeouts == 0) begin
                run_test(row);
            end
        end
        @(posedge clock);

        $display("tests run %0d, failed %0d, timeouts %0d", tests_done, tests_failed, timeouts);
        if (tests_failed == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+design
design/graph_pkg.sv
design/fsm_pkg.sv
design/scatter_if.sv
design/edge_scatter.sv
design/rank_accumulator.sv
design/rank_damper.sv
design/pagerank_ctrl.sv
design/pagerank_top.sv
tests/pagerank_checker.sv
tests/pagerank_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f project.f \
    --top-module pagerank_tb \
    -o pagerank_sim

./obj_dir/pagerank_sim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
